//--- tb.f
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/alu.sv
verilog/regFile.sv
verilog/loadMask.sv
verilog/dataPath.sv
verilog/mipsCpu.sv
bench/cpuTb.sv

//--- Bender.yml
package:
  name: mipsCpu

sources:
  - verilog/mipsPkg.sv
  - verilog/instrDecoder.sv
  - verilog/alu.sv
  - verilog/regFile.sv
  - verilog/loadMask.sv
  - verilog/dataPath.sv
  - verilog/mipsCpu.sv
  - target: test
    files:
      - bench/cpuTb.sv

//--- bench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
   import mipsPkg::*;

   localparam int memWords = 256;
   // Cycles each program gets to run
   localparam int runBudget = 100;
   localparam int runCount = 5;
   // Upper estimate of APB transfers, four cycles at most each
   localparam int apbCount = 300;
   localparam int timeoutCycles = runCount * runBudget + apbCount * 4 + 200;
   localparam wordT marker = 32'ha5a5_5a5a;

   logic clk, reset, pSel, pEnable, pWrite, pReady, pSlvErr;
   logic [15:0] pAddr;
   wordT pWData, pRData;

   integer seed;
   int errors, checks, cycles;
   wordT prog[$];
   logic [15:0] expAddr[$];
   wordT expVal[$];
   logic [15:0] storeAddr;

   mipsCpu #(.memWords(memWords)) mipsCpu_i (
      .clk(clk), .reset(reset), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
      .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > timeoutCycles) begin
         $display("Run stopped after %0d cycles without finishing the tests", timeoutCycles);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic checkErr(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error pSlvErr %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic checkWaits(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("error pReady wait states %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // Setup phase, then access phase until pReady, sampled at the falling edge
   task automatic apbTransfer(input logic write, input logic [15:0] addr, input wordT wdata,
                              output wordT rdata, output logic err, output int waits);
      @(posedge clk);
      #1;
      pSel = 1'b1;
      pEnable = 1'b0;
      pWrite = write;
      pAddr = addr;
      pWData = wdata;
      @(posedge clk);
      #1;
      pEnable = 1'b1;
      waits = 0;
      @(negedge clk);
      while (!pReady) begin
         waits++;
         @(negedge clk);
      end
      rdata = pRData;
      err = pSlvErr;
      @(posedge clk);
      #1;
      pSel = 1'b0;
      pEnable = 1'b0;
      pWrite = 1'b0;
   endtask

   task automatic apbWrite(input logic [15:0] addr, input wordT data, input logic expErr);
      wordT unused;
      logic err;
      int waits;
      apbTransfer(1'b1, addr, data, unused, err, waits);
      checkErr($sformatf("on write to 0x%04h", addr), err, expErr);
      checkWaits($sformatf("on write to 0x%04h", addr), waits, 0);
   endtask

   task automatic apbRead(input logic [15:0] addr, output wordT data, input logic expErr);
      logic err;
      int waits;
      apbTransfer(1'b0, addr, '0, data, err, waits);
      checkErr($sformatf("on read of 0x%04h", addr), err, expErr);
      // Only a good memory read waits, for the RAM
      checkWaits($sformatf("on read of 0x%04h", addr), waits,
                 (expErr || addr == 16'h2000) ? 0 : 1);
   endtask

   // Assembler through the union views
   function automatic wordT rInstr(input functT funct, input logic [4:0] rs, rt, rd, shamt);
      instrT w;
      w.r.opcode = opRType;
      w.r.rs = rs;
      w.r.rt = rt;
      w.r.rd = rd;
      w.r.shamt = shamt;
      w.r.funct = funct;
      return w;
   endfunction

   function automatic wordT iInstr(input opcodeT op, input logic [4:0] rs, rt,
                                   input logic [15:0] imm);
      instrT w;
      w.i.opcode = op;
      w.i.rs = rs;
      w.i.rt = rt;
      w.i.imm = imm;
      return w;
   endfunction

   function automatic wordT jInstr(input opcodeT op, input logic [25:0] target);
      instrT w;
      w.j.opcode = op;
      w.j.target = target;
      return w;
   endfunction

   task automatic recordExpected(input logic [15:0] addr, input wordT value);
      expAddr.push_back(addr);
      expVal.push_back(value);
   endtask

   // lui plus ori
   task automatic loadConst(input logic [4:0] rd, input wordT value);
      prog.push_back(iInstr(opLui, 5'd0, rd, value[31:16]));
      prog.push_back(iInstr(opOri, rd, rd, value[15:0]));
   endtask

   // Store to the next free result slot
   task automatic storeWord(input logic [4:0] rt, input wordT expected);
      prog.push_back(iInstr(opSw, 5'd0, rt, storeAddr));
      recordExpected(storeAddr, expected);
      storeAddr += 16'd4;
   endtask

   // A store the program must skip, slot prefilled with the marker
   task automatic skipStore(input logic [4:0] rt);
      prog.push_back(iInstr(opSw, 5'd0, rt, storeAddr));
      apbWrite(16'h1000 + storeAddr, marker, 1'b0);
      recordExpected(storeAddr, marker);
      storeAddr += 16'd4;
   endtask

   task automatic runProgram();
      wordT got;
      // Park in a self loop with a nop delay slot
      prog.push_back(iInstr(opBeq, 5'd0, 5'd0, 16'hffff));
      prog.push_back(rInstr(functSll, 5'd0, 5'd0, 5'd0, 5'd0));
      foreach (prog[k])
         apbWrite(16'(4 * k), prog[k], 1'b0);
      apbWrite(16'h2000, 32'd1, 1'b0);
      repeat (runBudget) @(posedge clk);
      apbWrite(16'h2000, 32'd0, 1'b0);
      foreach (expAddr[k]) begin
         apbRead(16'h1000 + expAddr[k], got, 1'b0);
         checkWord($sformatf("dmem[0x%03h]", expAddr[k]), got, expVal[k]);
      end
      prog.delete();
      expAddr.delete();
      expVal.delete();
      storeAddr = 16'h200;
   endtask

   task automatic apbTest();
      wordT got, v;
      v = $random(seed);
      apbRead(16'h2000, got, 1'b0);
      checkWord("run after reset", got, 32'd0);
      apbWrite(16'h1010, v, 1'b0);
      apbRead(16'h1010, got, 1'b0);
      checkWord("dmem[0x010]", got, v);
      apbRead(16'h3000, got, 1'b1);
      checkWord("unmapped read data", got, 32'd0);
      // Past the end of instruction memory
      apbWrite(16'h0400, v, 1'b1);
      apbWrite(16'h0000, iInstr(opBeq, 5'd0, 5'd0, 16'hffff), 1'b0);
      apbWrite(16'h0004, rInstr(functSll, 5'd0, 5'd0, 5'd0, 5'd0), 1'b0);
      apbWrite(16'h2000, 32'd1, 1'b0);
      apbRead(16'h2000, got, 1'b0);
      checkWord("run while set", got, 32'd1);
      apbWrite(16'h1010, ~v, 1'b1);
      apbRead(16'h1010, got, 1'b1);
      checkWord("dmem read while running", got, 32'd0);
      apbWrite(16'h2000, 32'd0, 1'b0);
      apbRead(16'h1010, got, 1'b0);
      checkWord("dmem[0x010] after blocked write", got, v);
   endtask

   task automatic emitRegOp(input functT funct, input logic [4:0] shamt, input wordT exp);
      prog.push_back(rInstr(funct, 5'd1, 5'd2, 5'd3, shamt));
      storeWord(5'd3, exp);
   endtask

   task automatic emitImmOp(input opcodeT op, input logic [15:0] imm, input wordT exp);
      prog.push_back(iInstr(op, 5'd1, 5'd3, imm));
      storeWord(5'd3, exp);
   endtask

   // Every ALU instruction, r1 and r2 random
   task automatic aluTest();
      wordT a, b, sext, zext;
      logic [15:0] imm;
      logic [4:0] sh;
      for (int round = 0; round < 2; round++) begin
         a = $random(seed);
         b = $random(seed);
         imm = $random(seed);
         sh = $random(seed);
         sext = {{16{imm[15]}}, imm};
         zext = {16'h0000, imm};
         loadConst(5'd1, a);
         loadConst(5'd2, b);
         emitRegOp(functAddu, 5'd0, a + b);
         emitRegOp(functSubu, 5'd0, a - b);
         emitRegOp(functAnd, 5'd0, a & b);
         emitRegOp(functOr, 5'd0, a | b);
         emitRegOp(functXor, 5'd0, a ^ b);
         emitRegOp(functSlt, 5'd0, {31'b0, $signed(a) < $signed(b)});
         emitRegOp(functSltu, 5'd0, {31'b0, a < b});
         emitRegOp(functSll, sh, b << sh);
         emitRegOp(functSrl, sh, b >> sh);
         emitRegOp(functSra, sh, $signed(b) >>> sh);
         emitImmOp(opAddiu, imm, a + sext);
         emitImmOp(opSlti, imm, {31'b0, $signed(a) < $signed(sext)});
         emitImmOp(opAndi, imm, a & zext);
         emitImmOp(opOri, imm, a | zext);
         emitImmOp(opXori, imm, a ^ zext);
         emitImmOp(opLui, imm, {imm, 16'h0000});
         runProgram();
      end
   endtask

   task automatic chainTest();
      wordT a, v3, v5;
      logic [15:0] first, ptrSlot;
      a = $random(seed);
      v3 = (a + a) ^ a;
      v5 = (v3 << 3) + 32'hffff_8123;
      loadConst(5'd1, a);
      // Each one consumes the result just before it
      prog.push_back(rInstr(functAddu, 5'd1, 5'd1, 5'd2, 5'd0));
      prog.push_back(rInstr(functXor, 5'd2, 5'd1, 5'd3, 5'd0));
      prog.push_back(rInstr(functSll, 5'd0, 5'd3, 5'd4, 5'd3));
      prog.push_back(iInstr(opAddiu, 5'd4, 5'd5, 16'h8123));
      first = storeAddr;
      storeWord(5'd5, v5);
      // Load-use into the ALU, then into store data
      prog.push_back(iInstr(opLw, 5'd0, 5'd6, first));
      prog.push_back(rInstr(functSubu, 5'd6, 5'd1, 5'd7, 5'd0));
      storeWord(5'd7, v5 - a);
      prog.push_back(iInstr(opLw, 5'd0, 5'd8, first));
      storeWord(5'd8, v5);
      // Loaded pointer as base address
      prog.push_back(iInstr(opAddiu, 5'd0, 5'd9, 16'h02f0));
      ptrSlot = storeAddr;
      storeWord(5'd9, 32'h0000_02f0);
      prog.push_back(iInstr(opLw, 5'd0, 5'd10, ptrSlot));
      prog.push_back(iInstr(opSw, 5'd10, 5'd5, 16'h0004));
      recordExpected(16'h02f4, v5);
      // Two apart, through the register file bypass
      prog.push_back(iInstr(opOri, 5'd0, 5'd11, 16'h0a5c));
      prog.push_back(rInstr(functSll, 5'd0, 5'd0, 5'd0, 5'd0));
      prog.push_back(rInstr(functAddu, 5'd11, 5'd5, 5'd12, 5'd0));
      storeWord(5'd12, v5 + 32'h0000_0a5c);
      runProgram();
   endtask

   task automatic byteTest();
      wordT p, q, r, w;
      logic [7:0] b;
      logic [15:0] h;
      p = $random(seed);
      q = $random(seed);
      r = $random(seed);
      apbWrite(16'h1300, p, 1'b0);
      loadConst(5'd1, r);
      // Byte 0 sits in bits 7:0
      for (int k = 0; k < 4; k++) begin
         b = p[8*k +: 8];
         prog.push_back(iInstr(opLb, 5'd0, 5'd2, 16'(16'h300 + k)));
         storeWord(5'd2, {{24{b[7]}}, b});
         prog.push_back(iInstr(opLbu, 5'd0, 5'd2, 16'(16'h300 + k)));
         storeWord(5'd2, {24'h0, b});
      end
      for (int k = 0; k < 4; k += 2) begin
         h = p[8*k +: 16];
         prog.push_back(iInstr(opLh, 5'd0, 5'd2, 16'(16'h300 + k)));
         storeWord(5'd2, {{16{h[15]}}, h});
         prog.push_back(iInstr(opLhu, 5'd0, 5'd2, 16'(16'h300 + k)));
         storeWord(5'd2, {16'h0, h});
      end
      // Narrow stores into prefilled words, one lane each
      for (int k = 0; k < 4; k++) begin
         apbWrite(16'(16'h1340 + 4 * k), q, 1'b0);
         prog.push_back(iInstr(opSb, 5'd0, 5'd1, 16'(16'h340 + 5 * k)));
         w = q;
         w[8*k +: 8] = r[7:0];
         recordExpected(16'(16'h340 + 4 * k), w);
      end
      for (int k = 0; k < 4; k += 2) begin
         apbWrite(16'(16'h1350 + 2 * k), q, 1'b0);
         prog.push_back(iInstr(opSh, 5'd0, 5'd1, 16'(16'h350 + 3 * k)));
         w = q;
         w[8*k +: 16] = r[15:0];
         recordExpected(16'(16'h350 + 2 * k), w);
      end
      runProgram();
   endtask

   // Word index in comments, delay slot right after each control transfer
   task automatic branchTest();
      prog.push_back(iInstr(opAddiu, 5'd0, 5'd1, 16'd5));
      prog.push_back(iInstr(opAddiu, 5'd0, 5'd2, 16'd5));
      prog.push_back(iInstr(opAddiu, 5'd0, 5'd3, 16'd7));
      // 3: beq taken to 6
      prog.push_back(iInstr(opBeq, 5'd1, 5'd2, 16'd2));
      storeWord(5'd1, 32'd5);
      skipStore(5'd1);
      // 6: bne taken to 9
      prog.push_back(iInstr(opBne, 5'd1, 5'd3, 16'd2));
      storeWord(5'd3, 32'd7);
      skipStore(5'd3);
      // 9: beq not taken, so 11 still runs instead of a jump to 12
      prog.push_back(iInstr(opBeq, 5'd1, 5'd3, 16'd2));
      storeWord(5'd2, 32'd5);
      storeWord(5'd3, 32'd7);
      // 12: j to 15
      prog.push_back(jInstr(opJ, 26'd15));
      storeWord(5'd1, 32'd5);
      skipStore(5'd1);
      // 15: jal to 18
      prog.push_back(jInstr(opJal, 26'd18));
      storeWord(5'd2, 32'd5);
      skipStore(5'd1);
      storeWord(5'd31, 32'(4 * 15 + 8));
      // 19: jr to 23
      prog.push_back(iInstr(opAddiu, 5'd0, 5'd4, 16'(4 * 23)));
      prog.push_back(rInstr(functJr, 5'd4, 5'd0, 5'd0, 5'd0));
      storeWord(5'd3, 32'd7);
      skipStore(5'd3);
      storeWord(5'd4, 32'(4 * 23));
      runProgram();
   endtask

   initial begin
      seed = 83413;
      errors = 0;
      checks = 0;
      cycles = 0;
      storeAddr = 16'h200;
      reset = 1'b0;
      pSel = 1'b0;
      pEnable = 1'b0;
      pWrite = 1'b0;
      pAddr = '0;
      pWData = '0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b1;
      apbTest();
      aluTest();
      chainTest();
      byteTest();
      branchTest();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/mipsCpu.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCpu #(
   parameter int memWords = 256
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          pSel,
   input  logic          pEnable,
   input  logic          pWrite,
   input  logic [15:0]   pAddr,
   input  mipsPkg::wordT pWData,
   output mipsPkg::wordT pRData,
   output logic          pReady,
   output logic          pSlvErr
);
   import mipsPkg::*;

   localparam int addrBits = $clog2(memWords);

   wordT instrMem [memWords];
   wordT dataMem [memWords];
   wordT instrOut, dataOut, coreWrite, dmemWData;
   logic [addrBits-1:0] coreInstrAddr, coreDataAddr, apbAddr, imemAddr, dmemAddr;
   logic [3:0] coreByteEn, dmemBe;
   logic run, coreReset, access, inRange, imemSel, dmemSel, ctrlSel, memSel, apbErr;
   logic memRead, readWait, imemWe;

   // APB decode, 4 KB regions
   assign access = pSel && pEnable;
   assign inRange = pAddr[11:2] < memWords;
   assign imemSel = pAddr[15:12] == 4'h0 && inRange;
   assign dmemSel = pAddr[15:12] == 4'h1 && inRange;
   assign ctrlSel = pAddr == 16'h2000;
   assign memSel = imemSel || dmemSel;
   // Memories belong to the core while it runs
   assign apbErr = !(memSel || ctrlSel) || (memSel && run);
   assign apbAddr = pAddr[addrBits+1:2];

   // RAM reads need one wait state
   assign memRead = access && !pWrite && memSel && !apbErr;
   assign pReady = access && (!memRead || readWait);
   assign pSlvErr = access && apbErr;

   always_comb begin
      if (!access || pWrite || apbErr)
         pRData = '0;
      else if (ctrlSel)
         pRData = {31'b0, run};
      else if (imemSel)
         pRData = instrOut;
      else
         pRData = dataOut;
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         run <= 1'b0;
         readWait <= 1'b0;
      end else begin
         readWait <= memRead && !readWait;
         if (access && pWrite && ctrlSel)
            run <= pWData[0];
      end
   end

   // Core held in reset whenever stopped
   assign coreReset = reset && run;

   // Instruction RAM, port shared by run
   assign imemAddr = run ? coreInstrAddr : apbAddr;
   assign imemWe = access && pWrite && imemSel && !run;
   always_ff @(posedge clk) begin
      if (imemWe)
         instrMem[imemAddr] <= pWData;
      instrOut <= instrMem[imemAddr];
   end

   // Data RAM with byte lanes
   assign dmemAddr = run ? coreDataAddr : apbAddr;
   assign dmemWData = run ? coreWrite : pWData;
   assign dmemBe = run ? coreByteEn : {4{access && pWrite && dmemSel}};
   always_ff @(posedge clk) begin
      for (int lane = 0; lane < 4; lane++) begin
         if (dmemBe[lane])
            dataMem[dmemAddr][8*lane +: 8] <= dmemWData[8*lane +: 8];
      end
      dataOut <= dataMem[dmemAddr];
   end

   dataPath #(.memWords(memWords)) dataPath_i (
      .clk(clk), .reset(coreReset), .instrAddr(coreInstrAddr), .instrWord(instrOut),
      .dataAddr(coreDataAddr), .dataWrite(coreWrite), .dataByteEn(coreByteEn),
      .dataRead(dataOut)
   );

   // Core stopped for a full cycle never stores, so APB owns the data RAM
   quietWhenStopped: assert property (@(posedge clk) disable iff (!reset)
      !run && !$past(run) |-> coreByteEn == 4'b0000);

endmodule

`default_nettype wire

//--- verilog/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
   parameter int memWords = 256
) (
   input  logic                        clk,
   input  logic                        reset,
   output logic [$clog2(memWords)-1:0] instrAddr,
   input  mipsPkg::wordT               instrWord,
   output logic [$clog2(memWords)-1:0] dataAddr,
   output mipsPkg::wordT               dataWrite,
   output logic [3:0]                  dataByteEn,
   input  mipsPkg::wordT               dataRead
);
   import mipsPkg::*;

   localparam int addrBits = $clog2(memWords);

   // Fetch/decode
   wordT pc, nextPc, immF, rsValF, rtValF;
   logic fetchValid;
   aluOpT aluOpF;
   memSizeT memSizeF;
   logic regWriteF, regDstF, aluSrcF, signExtF, memToRegF, memWriteF;
   logic isBranchF, branchNeF, jumpF, jumpRegF, linkF, loadSignedF;
   logic [4:0] waF;

   // Execute
   wordT pcE, immE, rsValE, rtValE, rsFwdE, rtFwdE, aluB, aluResult, pcPlus4E, execResult;
   aluOpT aluOpE;
   memSizeT memSizeE;
   logic regWriteE, memToRegE, memWriteE, isBranchE, branchNeE, jumpE, jumpRegE, linkE;
   logic aluSrcE, loadSignedE, branchTaken;
   logic [4:0] rsE, rtE, waE, shamtE;
   logic [25:0] targetE;
   logic [1:0] offsetE;
   logic [3:0] storeEn;

   // Memory/write-back
   wordT resultM, loadDataM, wbData;
   memSizeT memSizeM;
   logic regWriteM, memToRegM, loadSignedM;
   logic [4:0] waM;
   logic [1:0] offsetM;

   instrDecoder decoder_i (
      .instr(instrWord), .aluOp(aluOpF), .regWrite(regWriteF), .regDst(regDstF),
      .aluSrc(aluSrcF), .signExt(signExtF), .memToReg(memToRegF), .memWrite(memWriteF),
      .isBranch(isBranchF), .branchNe(branchNeF), .jump(jumpF), .jumpReg(jumpRegF),
      .link(linkF), .memSize(memSizeF), .loadSigned(loadSignedF)
   );

   regFile regFile_i (
      .clk(clk), .writeEn(regWriteM), .readAddrA(instrWord[25:21]),
      .readAddrB(instrWord[20:16]), .writeAddr(waM), .writeData(wbData),
      .readDataA(rsValF), .readDataB(rtValF)
   );

   assign immF = {{16{signExtF & instrWord[15]}}, instrWord[15:0]};
   // jal always targets $ra
   assign waF = linkF ? 5'd31 : (regDstF ? instrWord[15:11] : instrWord[20:16]);

   // Redirect lands after the delay slot now in fetch
   always_comb begin
      if (!fetchValid)
         nextPc = pc;
      else if (jumpRegE)
         nextPc = rsFwdE;
      else if (jumpE)
         nextPc = {pcPlus4E[31:28], targetE, 2'b00};
      else if (branchTaken)
         nextPc = pcPlus4E + {immE[29:0], 2'b00};
      else
         nextPc = pc + 32'd4;
   end
   assign instrAddr = nextPc[addrBits+1:2];

   // First cycle out of reset has no word from memory yet
   always_ff @(posedge clk) begin
      if (!reset) begin
         pc <= '0;
         fetchValid <= 1'b0;
      end else begin
         pc <= nextPc;
         fetchValid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         regWriteE <= 1'b0;
         memToRegE <= 1'b0;
         memWriteE <= 1'b0;
         isBranchE <= 1'b0;
         jumpE <= 1'b0;
         jumpRegE <= 1'b0;
         linkE <= 1'b0;
         regWriteM <= 1'b0;
         memToRegM <= 1'b0;
      end else begin
         regWriteE <= regWriteF & fetchValid;
         memToRegE <= memToRegF & fetchValid;
         memWriteE <= memWriteF & fetchValid;
         isBranchE <= isBranchF & fetchValid;
         jumpE <= jumpF & fetchValid;
         jumpRegE <= jumpRegF & fetchValid;
         linkE <= linkF & fetchValid;
         regWriteM <= regWriteE;
         memToRegM <= memToRegE;
      end
   end

   // Operands and fields carried along
   always_ff @(posedge clk) begin
      pcE <= pc;
      immE <= immF;
      rsValE <= rsValF;
      rtValE <= rtValF;
      rsE <= instrWord[25:21];
      rtE <= instrWord[20:16];
      waE <= waF;
      shamtE <= instrWord[10:6];
      targetE <= instrWord[25:0];
      aluOpE <= aluOpF;
      aluSrcE <= aluSrcF;
      branchNeE <= branchNeF;
      memSizeE <= memSizeF;
      loadSignedE <= loadSignedF;
      resultM <= execResult;
      waM <= waE;
      memSizeM <= memSizeE;
      loadSignedM <= loadSignedE;
      offsetM <= offsetE;
   end

   // Write-back value forwarded into execute, loads included
   assign rsFwdE = (regWriteM && waM != 5'd0 && waM == rsE) ? wbData : rsValE;
   assign rtFwdE = (regWriteM && waM != 5'd0 && waM == rtE) ? wbData : rtValE;
   assign aluB = aluSrcE ? immE : rtFwdE;

   alu alu_i (
      .a(rsFwdE), .b(aluB), .shamt(shamtE), .op(aluOpE), .result(aluResult)
   );

   assign pcPlus4E = pcE + 32'd4;
   assign branchTaken = isBranchE && ((rsFwdE == rtFwdE) != branchNeE);
   // Link address skips the delay slot
   assign execResult = linkE ? pcE + 32'd8 : aluResult;

   // Offset held at zero outside loads and stores
   assign offsetE = (memWriteE || memToRegE) ? aluResult[1:0] : 2'b00;
   assign dataAddr = aluResult[addrBits+1:2];
   assign dataByteEn = memWriteE ? storeEn : 4'b0000;

   // Store lanes in execute
   loadMask storeMask_i (
      .memSize(memSizeE), .loadSigned(1'b0), .byteOffset(offsetE), .memWord('0),
      .storeData(rtFwdE), .loadData(), .laneData(dataWrite), .byteEnable(storeEn)
   );

   // Load extraction once the read word is back
   loadMask loadMask_i (
      .memSize(memSizeM), .loadSigned(loadSignedM), .byteOffset(offsetM),
      .memWord(dataRead), .storeData('0), .loadData(loadDataM), .laneData(),
      .byteEnable()
   );

   assign wbData = memToRegM ? loadDataM : resultM;

   // Holds even across jr targets
   pcAligned: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/loadMask.sv
`timescale 1ns/1ps
`default_nettype none

module loadMask (
   input  mipsPkg::memSizeT memSize,
   input  logic             loadSigned,
   input  logic [1:0]       byteOffset,
   input  mipsPkg::wordT    memWord,
   input  mipsPkg::wordT    storeData,
   output mipsPkg::wordT    loadData,
   output mipsPkg::wordT    laneData,
   output logic [3:0]       byteEnable
);
   import mipsPkg::*;

   logic [7:0]  selByte;
   logic [15:0] selHalf;

   // Little-endian lanes, byte 0 in bits 7:0
   assign selByte = memWord[{byteOffset, 3'b000} +: 8];
   assign selHalf = memWord[{byteOffset[1], 4'b0000} +: 16];

   always_comb begin
      case (memSize)
         sizeByte: begin
            loadData = {{24{loadSigned & selByte[7]}}, selByte};
            laneData = {4{storeData[7:0]}};
            byteEnable = 4'b0001 << byteOffset;
         end
         sizeHalf: begin
            loadData = {{16{loadSigned & selHalf[15]}}, selHalf};
            laneData = {2{storeData[15:0]}};
            byteEnable = byteOffset[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            loadData = memWord;
            laneData = storeData;
            byteEnable = 4'b1111;
         end
      endcase
   end

   // Halves on even bytes, words on word boundaries
   naturalAlign: assert final (memSize == sizeByte ||
                               (memSize == sizeHalf && !byteOffset[0]) ||
                               byteOffset == 2'b00);

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic          clk,
   input  logic          writeEn,
   input  logic [4:0]    readAddrA,
   input  logic [4:0]    readAddrB,
   input  logic [4:0]    writeAddr,
   input  mipsPkg::wordT writeData,
   output mipsPkg::wordT readDataA,
   output mipsPkg::wordT readDataB
);
   import mipsPkg::*;

   // $zero has no storage
   wordT regs [1:31];

   always_ff @(posedge clk) begin
      if (writeEn && writeAddr != 5'd0)
         regs[writeAddr] <= writeData;
   end

   // Same-cycle write shows through to decode
   assign readDataA = (readAddrA == 5'd0) ? '0 :
                      (writeEn && readAddrA == writeAddr) ? writeData : regs[readAddrA];
   assign readDataB = (readAddrB == 5'd0) ? '0 :
                      (writeEn && readAddrB == writeAddr) ? writeData : regs[readAddrB];

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  mipsPkg::wordT  a,
   input  mipsPkg::wordT  b,
   input  logic [4:0]     shamt,
   input  mipsPkg::aluOpT op,
   output mipsPkg::wordT  result
);
   import mipsPkg::*;

   always_comb begin
      case (op)
         aluAdd:  result = a + b;
         aluSub:  result = a - b;
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         aluXor:  result = a ^ b;
         aluNor:  result = ~(a | b);
         // Compares give 0 or 1
         aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
         aluSltu: result = {31'b0, a < b};
         // Shifts act on b, amount from the shamt field
         aluSll:  result = b << shamt;
         aluSrl:  result = b >> shamt;
         aluSra:  result = $signed(b) >>> shamt;
         // Immediate into the upper half
         aluLui:  result = {b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  mipsPkg::instrT   instr,
   output mipsPkg::aluOpT   aluOp,
   output logic             regWrite,
   output logic             regDst,
   output logic             aluSrc,
   output logic             signExt,
   output logic             memToReg,
   output logic             memWrite,
   output logic             isBranch,
   output logic             branchNe,
   output logic             jump,
   output logic             jumpReg,
   output logic             link,
   output mipsPkg::memSizeT memSize,
   output logic             loadSigned
);
   import mipsPkg::*;

   always_comb begin
      // Unknown words fall through as a no-op
      aluOp = aluAdd;
      regWrite = 1'b0;
      regDst = 1'b0;
      aluSrc = 1'b0;
      signExt = 1'b0;
      memToReg = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      branchNe = 1'b0;
      jump = 1'b0;
      jumpReg = 1'b0;
      link = 1'b0;
      memSize = sizeWord;
      loadSigned = 1'b0;
      case (instr.i.opcode)
         opRType: begin
            regWrite = 1'b1;
            regDst = 1'b1;
            // R view, funct picks the operation
            case (instr.r.funct)
               functAddu: aluOp = aluAdd;
               functSubu: aluOp = aluSub;
               functAnd:  aluOp = aluAnd;
               functOr:   aluOp = aluOr;
               functXor:  aluOp = aluXor;
               functSlt:  aluOp = aluSlt;
               functSltu: aluOp = aluSltu;
               functSll:  aluOp = aluSll;
               functSrl:  aluOp = aluSrl;
               functSra:  aluOp = aluSra;
               functJr: begin
                  regWrite = 1'b0;
                  jumpReg = 1'b1;
               end
               default: regWrite = 1'b0;
            endcase
         end
         opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
            regWrite = 1'b1;
            aluSrc = 1'b1;
            // Logic immediates are zero extended
            signExt = instr.i.opcode inside {opAddiu, opSlti};
            case (instr.i.opcode)
               opSlti:  aluOp = aluSlt;
               opAndi:  aluOp = aluAnd;
               opOri:   aluOp = aluOr;
               opXori:  aluOp = aluXor;
               opLui:   aluOp = aluLui;
               default: aluOp = aluAdd;
            endcase
         end
         opBeq, opBne: begin
            isBranch = 1'b1;
            branchNe = instr.i.opcode == opBne;
            signExt = 1'b1;
         end
         opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw: begin
            aluSrc = 1'b1;
            signExt = 1'b1;
            // Bit 3 marks stores, bit 2 unsigned loads
            memWrite = instr.i.opcode[3];
            memToReg = !instr.i.opcode[3];
            regWrite = !instr.i.opcode[3];
            loadSigned = !instr.i.opcode[2];
            if (instr.i.opcode[1])
               memSize = sizeWord;
            else
               memSize = instr.i.opcode[0] ? sizeHalf : sizeByte;
         end
         opJ, opJal: begin
            jump = 1'b1;
            link = instr.i.opcode == opJal;
            regWrite = instr.i.opcode == opJal;
         end
         default: regWrite = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

   typedef logic [31:0] wordT;

   // Major opcodes, zero hands decoding to funct
   typedef enum logic [5:0] {
      opRType = 6'h00, opJ = 6'h02, opJal = 6'h03, opBeq = 6'h04, opBne = 6'h05,
      opAddiu = 6'h09, opSlti = 6'h0a, opAndi = 6'h0c, opOri = 6'h0d,
      opXori = 6'h0e, opLui = 6'h0f,
      opLb = 6'h20, opLh = 6'h21, opLw = 6'h23, opLbu = 6'h24, opLhu = 6'h25,
      opSb = 6'h28, opSh = 6'h29, opSw = 6'h2b
   } opcodeT;

   // R-type function field
   typedef enum logic [5:0] {
      functSll = 6'h00, functSrl = 6'h02, functSra = 6'h03, functJr = 6'h08,
      functAddu = 6'h21, functSubu = 6'h23, functAnd = 6'h24, functOr = 6'h25,
      functXor = 6'h26, functSlt = 6'h2a, functSltu = 6'h2b
   } functT;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
   } aluOpT;

   // Access width of loads and stores
   typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSizeT;

   typedef struct packed {
      opcodeT     opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      functT      funct;
   } rTypeT;

   typedef struct packed {
      opcodeT      opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } iTypeT;

   typedef struct packed {
      opcodeT      opcode;
      logic [25:0] target;
   } jTypeT;

   // One instruction word, three views
   typedef union packed {
      rTypeT r;
      iTypeT i;
      jTypeT j;
   } instrT;

endpackage

`default_nettype wire
